// ==== bench/rvfi_chk.sv ====
// Trace checker bound to rvfi_top; it assumes the instruction after a trap is not a debug entry

`include "rvfi_defs.svh"

module rvfi_chk (
  input logic                                      clk_i,
  input logic                                      rst_ni,
  input logic                                      irq_ack_i,
  input logic                                      dbg_ack_i,
  input logic [`RVFI_NSTAGES-1:0]                  stage_intr_i,
  input logic [`RVFI_NSTAGES-1:0][`RVFI_DBG_W-1:0] stage_dbg_i,
  input logic                                      rvfi_valid_i,
  input logic                                      rvfi_intr_i,
  input logic [`RVFI_DBG_W-1:0]                    rvfi_dbg_i,
  input logic                                      rvfi_trap_exc_i,
  input logic                                      rvfi_trap_dbg_i,
  input logic [`RVFI_EXC_W-1:0]                    rvfi_trap_cause_i,
  input logic [`RVFI_EXC_W-1:0]                    mcause_i,
  input logic                                      debug_mode_i
);

  import rvfi_pkg::*;

  // Debug acks not yet matched by a debug entry on the trace
  int                     dbg_open_q;
  // Last retirement was an exception taken in RUN, with its cause
  logic                   exc_seen_q;
  logic [`RVFI_EXC_W-1:0] exc_cause_q;
  // Last retirement was a step trap
  logic                   step_seen_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dbg_open_q  <= 0;
      exc_seen_q  <= 1'b0;
      exc_cause_q <= '0;
      step_seen_q <= 1'b0;
    end else begin
      if (dbg_ack_i && !(rvfi_valid_i && rvfi_dbg_i != DBG_NONE)) begin
        dbg_open_q <= dbg_open_q + 1;
      end else if (!dbg_ack_i && rvfi_valid_i && rvfi_dbg_i != DBG_NONE) begin
        dbg_open_q <= dbg_open_q - 1;
      end
      if (rvfi_valid_i) begin
        exc_seen_q  <= rvfi_trap_exc_i && !debug_mode_i;
        exc_cause_q <= rvfi_trap_cause_i;
        step_seen_q <= rvfi_trap_dbg_i;
      end
    end
  end

  //////////////////////////////
  // Capture in fetch
  //////////////////////////////

  irq_capture: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_ack_i |=> stage_intr_i[STAGE_IF])
    else $error("irq_ack not captured as intr in IF");

  dbg_capture: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dbg_ack_i |=> stage_dbg_i[STAGE_IF] != DBG_NONE)
    else $error("dbg_ack not captured as a debug cause in IF");

  //////////////////////////////
  // Trace ordering
  //////////////////////////////

  dbg_has_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rvfi_valid_i && rvfi_dbg_i != DBG_NONE) |-> dbg_open_q > 0)
    else $error("debug entry on the trace without an earlier dbg_ack");

  // The handler entry reports the cause of the exception before it
  exc_handler: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rvfi_valid_i && exc_seen_q) |-> (rvfi_intr_i && mcause_i == exc_cause_q))
    else $error("exception not followed by handler entry with its cause");

  step_entry: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rvfi_valid_i && step_seen_q) |-> rvfi_dbg_i == DBG_STEP)
    else $error("step trap not followed by a step debug entry");

endmodule

bind rvfi_top rvfi_chk u_rvfi_chk (
  .clk_i             (clk_i),
  .rst_ni            (rst_ni),
  .irq_ack_i         (irq_ack_o),
  .dbg_ack_i         (dbg_ack_o),
  .stage_intr_i      (stage_intr_o),
  .stage_dbg_i       (stage_dbg_o),
  .rvfi_valid_i      (rvfi_valid_o),
  .rvfi_intr_i       (rvfi_intr_o),
  .rvfi_dbg_i        (rvfi_dbg_o),
  .rvfi_trap_exc_i   (rvfi_trap_exc_o),
  .rvfi_trap_dbg_i   (rvfi_trap_dbg_o),
  .rvfi_trap_cause_i (rvfi_trap_cause_o),
  .mcause_i          (mcause_o),
  .debug_mode_i      (debug_mode_o)
);

// ==== bench/tb_clk.sv ====
// Testbench clock and reset source; period 10, reset held low over the first two rising edges

module tb_clk (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    // Release one time unit after the second edge, away from the sampling edge
    repeat (2) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

  always #5 clk_o = ~clk_o;

endmodule

// ==== bench/tb_top.sv ====
// Table-driven testbench; one instruction is in flight at a time so mcause is known at each retirement

`include "rvfi_defs.svh"

module tb_top;

  import rvfi_pkg::*;

  localparam int NROWS = 20;
  // Each row needs an offer and four unstalled edges, with about half the cycles stalled
  localparam int LIMIT = NROWS * 16 + 20;

  logic                   clk_i, rst_ni;
  logic                   instr_valid_i, instr_exc_i, stall_i;
  logic [`RVFI_EXC_W-1:0] instr_cause_i;
  logic                   irq_i, dbg_req_i, step_i, dbg_exit_i;
  logic                   rvfi_valid_o, rvfi_intr_o, rvfi_trap_exc_o, rvfi_trap_dbg_o;
  logic [`RVFI_DBG_W-1:0] rvfi_dbg_o, rvfi_trap_dbg_cause_o;
  logic [`RVFI_EXC_W-1:0] rvfi_trap_cause_o, mcause_o;
  logic                   irq_ack_o, dbg_ack_o, debug_mode_o;
  logic [`RVFI_NSTAGES-1:0]                  stage_intr_o;
  logic [`RVFI_NSTAGES-1:0][`RVFI_DBG_W-1:0] stage_dbg_o;

  //////////////////////////////
  // Stimulus table
  //////////////////////////////

  // Inputs offered with the row, then the expected retirement report
  logic                   t_exc[NROWS], t_irq[NROWS], t_req[NROWS], t_step[NROWS];
  logic                   t_exit[NROWS], x_intr[NROWS], x_texc[NROWS], x_tdbg[NROWS];
  logic [`RVFI_EXC_W-1:0] t_cause[NROWS], x_tcause[NROWS], x_mcause[NROWS];
  logic [`RVFI_DBG_W-1:0] x_dbg[NROWS], x_tdcause[NROWS];

  int         nrows;
  int         ret_cnt;
  int         errors;
  int         cycles;
  logic [7:0] lfsr;
  logic       taken;

  tb_clk u_tb_clk (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  rvfi_top UUT (.*);

  task automatic add_row(input logic exc, input logic [`RVFI_EXC_W-1:0] cause,
                         input logic irq, input logic req, input logic step, input logic ext,
                         input logic e_intr, input logic [`RVFI_DBG_W-1:0] e_dbg,
                         input logic e_texc, input logic [`RVFI_EXC_W-1:0] e_tcause,
                         input logic e_tdbg, input logic [`RVFI_DBG_W-1:0] e_tdcause,
                         input logic [`RVFI_EXC_W-1:0] e_mcause);
    t_exc[nrows]     = exc;
    t_cause[nrows]   = cause;
    t_irq[nrows]     = irq;
    t_req[nrows]     = req;
    t_step[nrows]    = step;
    t_exit[nrows]    = ext;
    x_intr[nrows]    = e_intr;
    x_dbg[nrows]     = e_dbg;
    x_texc[nrows]    = e_texc;
    x_tcause[nrows]  = e_tcause;
    x_tdbg[nrows]    = e_tdbg;
    x_tdcause[nrows] = e_tdcause;
    x_mcause[nrows]  = e_mcause;
    nrows++;
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  // 8-bit Fibonacci LFSR, taps 8 6 5 4
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  task automatic drive_stall();
    lfsr    = lfsr_next(lfsr);
    stall_i = lfsr[0];
  endtask

  task automatic check_idle_outputs();
    check_value("rvfi_valid_o", 32'(rvfi_valid_o), 32'h0);
    check_value("irq_ack_o", 32'(irq_ack_o), 32'h0);
    check_value("dbg_ack_o", 32'(dbg_ack_o), 32'h0);
    check_value("debug_mode_o", 32'(debug_mode_o), 32'h0);
  endtask

  //////////////////////////////
  // Retirement monitor
  //////////////////////////////

  // Outputs are registered on the rising edge, so the falling edge sees them settled
  always @(negedge clk_i) begin
    if (rst_ni && rvfi_valid_o) begin
      if (ret_cnt >= nrows) begin
        $display("Retirement seen with no instruction left in the table");
        errors++;
      end else begin
        check_value("rvfi_intr_o", 32'(rvfi_intr_o), 32'(x_intr[ret_cnt]));
        check_value("rvfi_dbg_o", 32'(rvfi_dbg_o), 32'(x_dbg[ret_cnt]));
        check_value("rvfi_trap_exc_o", 32'(rvfi_trap_exc_o), 32'(x_texc[ret_cnt]));
        check_value("rvfi_trap_cause_o", 32'(rvfi_trap_cause_o), 32'(x_tcause[ret_cnt]));
        check_value("rvfi_trap_dbg_o", 32'(rvfi_trap_dbg_o), 32'(x_tdbg[ret_cnt]));
        check_value("rvfi_trap_dbg_cause_o", 32'(rvfi_trap_dbg_cause_o),
                    32'(x_tdcause[ret_cnt]));
        check_value("mcause_o", 32'(mcause_o), 32'(x_mcause[ret_cnt]));
      end
      ret_cnt++;
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("Timeout: retirement did not complete, %0d of %0d rows retired", ret_cnt, nrows);
      $display("Errors: %0d", errors + 1);
      $display("Checks failed");
      $finish;
    end
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    instr_valid_i = 1'b0;
    instr_exc_i   = 1'b0;
    instr_cause_i = '0;
    stall_i       = 1'b0;
    irq_i         = 1'b0;
    dbg_req_i     = 1'b0;
    step_i        = 1'b0;
    dbg_exit_i    = 1'b0;
    lfsr          = 8'd7;
    nrows         = 0;
    ret_cnt       = 0;
    errors        = 0;
    cycles        = 0;

    // exc cause irq req step exit | intr dbg texc tcause tdbg tdcause mcause
    add_row(0, 6'd0,  0, 0, 0, 0, 0, DBG_NONE,    0, 6'd0,  0, DBG_NONE, 6'd0);
    add_row(0, 6'd0,  0, 0, 0, 0, 0, DBG_NONE,    0, 6'd0,  0, DBG_NONE, 6'd0);
    add_row(1, 6'd5,  0, 0, 0, 0, 0, DBG_NONE,    1, 6'd5,  0, DBG_NONE, 6'd5);
    add_row(0, 6'd0,  0, 0, 0, 0, 1, DBG_NONE,    0, 6'd0,  0, DBG_NONE, 6'd5);
    add_row(0, 6'd0,  0, 0, 0, 0, 0, DBG_NONE,    0, 6'd0,  0, DBG_NONE, 6'd5);
    add_row(0, 6'd0,  1, 0, 0, 0, 1, DBG_NONE,    0, 6'd0,  0, DBG_NONE, 6'd11);
    add_row(1, 6'd2,  0, 0, 0, 0, 0, DBG_NONE,    1, 6'd2,  0, DBG_NONE, 6'd2);
    add_row(0, 6'd0,  0, 0, 0, 0, 1, DBG_NONE,    0, 6'd0,  0, DBG_NONE, 6'd2);
    // Halt request wins over the interrupt offered with it
    add_row(0, 6'd0,  1, 1, 0, 0, 0, DBG_HALTREQ, 0, 6'd0,  0, DBG_NONE, 6'd2);
    add_row(0, 6'd0,  1, 0, 0, 0, 0, DBG_NONE,    0, 6'd0,  0, DBG_NONE, 6'd2);
    add_row(1, 6'd7,  0, 0, 0, 0, 0, DBG_NONE,    1, 6'd7,  0, DBG_NONE, 6'd2);
    add_row(0, 6'd0,  0, 0, 0, 1, 0, DBG_NONE,    0, 6'd0,  0, DBG_NONE, 6'd2);
    add_row(0, 6'd0,  1, 0, 0, 0, 1, DBG_NONE,    0, 6'd0,  0, DBG_NONE, 6'd11);
    add_row(0, 6'd0,  0, 0, 1, 0, 0, DBG_NONE,    0, 6'd0,  1, DBG_STEP, 6'd11);
    add_row(0, 6'd0,  0, 0, 0, 0, 0, DBG_STEP,    0, 6'd0,  0, DBG_NONE, 6'd11);
    // Stepping is ignored in debug mode
    add_row(0, 6'd0,  0, 0, 1, 0, 0, DBG_NONE,    0, 6'd0,  0, DBG_NONE, 6'd11);
    add_row(0, 6'd0,  0, 0, 0, 1, 0, DBG_NONE,    0, 6'd0,  0, DBG_NONE, 6'd11);
    add_row(1, 6'h3f, 0, 0, 0, 0, 0, DBG_NONE,    1, 6'h3f, 0, DBG_NONE, 6'h3f);
    add_row(0, 6'd0,  0, 0, 0, 0, 1, DBG_NONE,    0, 6'd0,  0, DBG_NONE, 6'h3f);
    add_row(0, 6'd0,  0, 0, 0, 0, 0, DBG_NONE,    0, 6'd0,  0, DBG_NONE, 6'h3f);

    @(negedge clk_i);
    check_idle_outputs();
    wait (rst_ni);
    @(negedge clk_i);
    check_idle_outputs();
    @(posedge clk_i);
    #1;

    for (int r = 0; r < NROWS; r++) begin
      // Exit debug in an idle cycle so the row itself is accepted in RUN
      if (t_exit[r]) begin
        dbg_exit_i = 1'b1;
        drive_stall();
        @(posedge clk_i);
        #1;
        dbg_exit_i = 1'b0;
      end
      instr_valid_i = 1'b1;
      instr_exc_i   = t_exc[r];
      instr_cause_i = t_cause[r];
      irq_i         = t_irq[r];
      dbg_req_i     = t_req[r];
      step_i        = t_step[r];
      taken         = 1'b0;
      while (!taken) begin
        drive_stall();
        @(posedge clk_i);
        taken = !stall_i;
        #1;
      end
      instr_valid_i = 1'b0;
      instr_exc_i   = 1'b0;
      instr_cause_i = '0;
      irq_i         = 1'b0;
      dbg_req_i     = 1'b0;
      step_i        = 1'b0;
      while (ret_cnt <= r) begin
        drive_stall();
        @(posedge clk_i);
        #1;
      end
    end

    // Leave room for any stray retirement to show up
    stall_i = 1'b0;
    repeat (8) @(posedge clk_i);
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== logic/rvfi_defs.svh ====
// Shared sizes and codes for the trace unit; RVFI_NSTAGES must match the entries of stage_e

`ifndef RVFI_DEFS_SVH
`define RVFI_DEFS_SVH

//////////////////////////////
// Pipeline geometry
//////////////////////////////

// Number of stages from fetch to writeback
`define RVFI_NSTAGES 4

//////////////////////////////
// Cause fields
//////////////////////////////

// Width of an exception cause and of the low mcause field
`define RVFI_EXC_W 6

// Width of a debug cause, the same as dcsr.cause
`define RVFI_DBG_W 3

// Cause code that mcause takes on interrupt entry (machine external interrupt)
`define RVFI_IRQ_CAUSE 11

`endif

// ==== logic/rvfi_pkg.sv ====
// Types shared by the trace RTL and its checker; the debug cause codes follow dcsr.cause

`include "rvfi_defs.svh"

package rvfi_pkg;

  //////////////////////////////
  // Pipeline stages
  //////////////////////////////

  // Index of each stage in the per-stage tag vectors
  typedef enum logic [1:0] {
    STAGE_IF = 2'd0,
    STAGE_ID = 2'd1,
    STAGE_EX = 2'd2,
    STAGE_WB = 2'd3
  } stage_e;

  //////////////////////////////
  // Debug causes
  //////////////////////////////

  // Encoded as in dcsr.cause
  // EBREAK is kept for the encoding only and is never produced here
  typedef enum logic [`RVFI_DBG_W-1:0] {
    DBG_NONE    = 3'd0,
    DBG_EBREAK  = 3'd1,
    DBG_HALTREQ = 3'd3,
    DBG_STEP    = 3'd4
  } dbg_cause_e;

  //////////////////////////////
  // Controller states
  //////////////////////////////

  // RUN takes traps normally, DEBUG freezes tagging until an exit pulse
  typedef enum logic {
    CTRL_RUN   = 1'b0,
    CTRL_DEBUG = 1'b1
  } ctrl_state_e;

endpackage

// ==== logic/rvfi_top.sv ====
// Trace unit top; the stage tag vectors are exported only for the bound checker

`include "rvfi_defs.svh"

module rvfi_top (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  // Instruction stream and back-pressure
  input  logic                                       instr_valid_i,
  input  logic                                       instr_exc_i,
  input  logic [`RVFI_EXC_W-1:0]                     instr_cause_i,
  input  logic                                       stall_i,
  // Trap and debug requests
  input  logic                                       irq_i,
  input  logic                                       dbg_req_i,
  input  logic                                       step_i,
  input  logic                                       dbg_exit_i,
  // Retirement trace
  output logic                                       rvfi_valid_o,
  output logic                                       rvfi_intr_o,
  output logic [`RVFI_DBG_W-1:0]                     rvfi_dbg_o,
  output logic                                       rvfi_trap_exc_o,
  output logic                                       rvfi_trap_dbg_o,
  output logic [`RVFI_EXC_W-1:0]                     rvfi_trap_cause_o,
  output logic [`RVFI_DBG_W-1:0]                     rvfi_trap_dbg_cause_o,
  // Acknowledgements and CSR state
  output logic                                       irq_ack_o,
  output logic                                       dbg_ack_o,
  output logic [`RVFI_EXC_W-1:0]                     mcause_o,
  output logic                                       debug_mode_o,
  // Stage tags
  output logic [`RVFI_NSTAGES-1:0]                   stage_intr_o,
  output logic [`RVFI_NSTAGES-1:0][`RVFI_DBG_W-1:0]  stage_dbg_o
);

  import rvfi_pkg::*;

  //////////////////////////////
  // Controller to tracker
  //////////////////////////////

  logic                   accept;
  logic                   tag_intr;
  dbg_cause_e             tag_dbg_cause;
  logic                   trap_exc;
  logic [`RVFI_EXC_W-1:0] trap_cause;
  logic                   trap_dbg;

  // Retirement feedback for the mcause update
  logic                   wb_retire;
  logic                   wb_trap_exc;
  logic [`RVFI_EXC_W-1:0] wb_trap_cause;

  trap_ctrl u_trap_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .instr_valid_i   (instr_valid_i),
    .instr_exc_i     (instr_exc_i),
    .instr_cause_i   (instr_cause_i),
    .stall_i         (stall_i),
    .irq_i           (irq_i),
    .dbg_req_i       (dbg_req_i),
    .step_i          (step_i),
    .dbg_exit_i      (dbg_exit_i),
    .wb_retire_i     (wb_retire),
    .wb_trap_exc_i   (wb_trap_exc),
    .wb_trap_cause_i (wb_trap_cause),
    .accept_o        (accept),
    .tag_intr_o      (tag_intr),
    .tag_dbg_cause_o (tag_dbg_cause),
    .trap_exc_o      (trap_exc),
    .trap_cause_o    (trap_cause),
    .trap_dbg_o      (trap_dbg),
    .irq_ack_o       (irq_ack_o),
    .dbg_ack_o       (dbg_ack_o),
    .mcause_o        (mcause_o),
    .debug_mode_o    (debug_mode_o)
  );

  rvfi_tracker u_rvfi_tracker (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .stall_i               (stall_i),
    .accept_i              (accept),
    .tag_intr_i            (tag_intr),
    .tag_dbg_cause_i       (tag_dbg_cause),
    .trap_exc_i            (trap_exc),
    .trap_cause_i          (trap_cause),
    .trap_dbg_i            (trap_dbg),
    .stage_intr_o          (stage_intr_o),
    .stage_dbg_o           (stage_dbg_o),
    .wb_retire_o           (wb_retire),
    .wb_trap_exc_o         (wb_trap_exc),
    .wb_trap_cause_o       (wb_trap_cause),
    .rvfi_valid_o          (rvfi_valid_o),
    .rvfi_intr_o           (rvfi_intr_o),
    .rvfi_dbg_o            (rvfi_dbg_o),
    .rvfi_trap_exc_o       (rvfi_trap_exc_o),
    .rvfi_trap_dbg_o       (rvfi_trap_dbg_o),
    .rvfi_trap_cause_o     (rvfi_trap_cause_o),
    .rvfi_trap_dbg_cause_o (rvfi_trap_dbg_cause_o)
  );

endmodule

// ==== logic/rvfi_tracker.sv ====
// Four-stage tag pipeline with registered retirement outputs; a stall holds every stage

`include "rvfi_defs.svh"

module rvfi_tracker (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                                       stall_i,
  // Tags of the instruction accepted this cycle
  input  logic                                       accept_i,
  input  logic                                       tag_intr_i,
  input  rvfi_pkg::dbg_cause_e                       tag_dbg_cause_i,
  input  logic                                       trap_exc_i,
  input  logic [`RVFI_EXC_W-1:0]                     trap_cause_i,
  input  logic                                       trap_dbg_i,
  // Per-stage tag vectors, indexed by stage
  output logic [`RVFI_NSTAGES-1:0]                   stage_intr_o,
  output logic [`RVFI_NSTAGES-1:0][`RVFI_DBG_W-1:0]  stage_dbg_o,
  // Retirement happening at the coming edge
  output logic                                       wb_retire_o,
  output logic                                       wb_trap_exc_o,
  output logic [`RVFI_EXC_W-1:0]                     wb_trap_cause_o,
  // Registered retirement report
  output logic                                       rvfi_valid_o,
  output logic                                       rvfi_intr_o,
  output logic [`RVFI_DBG_W-1:0]                     rvfi_dbg_o,
  output logic                                       rvfi_trap_exc_o,
  output logic                                       rvfi_trap_dbg_o,
  output logic [`RVFI_EXC_W-1:0]                     rvfi_trap_cause_o,
  output logic [`RVFI_DBG_W-1:0]                     rvfi_trap_dbg_cause_o
);

  import rvfi_pkg::*;

  // Control bits per stage
  logic [`RVFI_NSTAGES-1:0]                  valid_q;
  logic [`RVFI_NSTAGES-1:0]                  intr_q;
  logic [`RVFI_NSTAGES-1:0]                  exc_q;
  logic [`RVFI_NSTAGES-1:0]                  tdbg_q;
  logic [`RVFI_NSTAGES-1:0][`RVFI_DBG_W-1:0] dbg_q;

  // Exception cause per stage, only meaningful where exc_q is set
  logic [`RVFI_NSTAGES-1:0][`RVFI_EXC_W-1:0] cause_q;

  //////////////////////////////
  // Stage shift
  //////////////////////////////

  // On an unstalled edge every entry moves one stage on
  // IF takes the accepted instruction or a bubble
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      intr_q  <= '0;
      exc_q   <= '0;
      tdbg_q  <= '0;
      dbg_q   <= '0;
    end else if (!stall_i) begin
      for (int s = STAGE_WB; s > STAGE_IF; s--) begin
        valid_q[s] <= valid_q[s-1];
        intr_q[s]  <= intr_q[s-1];
        exc_q[s]   <= exc_q[s-1];
        tdbg_q[s]  <= tdbg_q[s-1];
        dbg_q[s]   <= dbg_q[s-1];
      end
      valid_q[STAGE_IF] <= accept_i;
      intr_q[STAGE_IF]  <= tag_intr_i;
      exc_q[STAGE_IF]   <= trap_exc_i;
      tdbg_q[STAGE_IF]  <= trap_dbg_i;
      dbg_q[STAGE_IF]   <= tag_dbg_cause_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      for (int s = STAGE_WB; s > STAGE_IF; s--) begin
        cause_q[s] <= cause_q[s-1];
      end
      cause_q[STAGE_IF] <= trap_cause_i;
    end
  end

  assign stage_intr_o = intr_q;
  assign stage_dbg_o  = dbg_q;

  //////////////////////////////
  // Retirement
  //////////////////////////////

  // WB leaves the pipe on any unstalled edge that finds it occupied
  assign wb_retire_o     = valid_q[STAGE_WB] && !stall_i;
  assign wb_trap_exc_o   = exc_q[STAGE_WB];
  assign wb_trap_cause_o = cause_q[STAGE_WB];

  // rvfi_valid is a one-cycle pulse after each retiring edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvfi_valid_o          <= 1'b0;
      rvfi_intr_o           <= 1'b0;
      rvfi_dbg_o            <= DBG_NONE;
      rvfi_trap_exc_o       <= 1'b0;
      rvfi_trap_dbg_o       <= 1'b0;
      rvfi_trap_dbg_cause_o <= DBG_NONE;
    end else begin
      rvfi_valid_o <= wb_retire_o;
      if (wb_retire_o) begin
        rvfi_intr_o     <= intr_q[STAGE_WB];
        rvfi_dbg_o      <= dbg_q[STAGE_WB];
        rvfi_trap_exc_o <= exc_q[STAGE_WB];
        rvfi_trap_dbg_o <= tdbg_q[STAGE_WB];
        // Only single step raises a debug trap here
        rvfi_trap_dbg_cause_o <= tdbg_q[STAGE_WB] ? DBG_STEP : DBG_NONE;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wb_retire_o) begin
      rvfi_trap_cause_o <= exc_q[STAGE_WB] ? cause_q[STAGE_WB] : '0;
    end
  end

endmodule

// ==== logic/trap_ctrl.sv ====
// Trap and debug entry controller; tags are combinational on acceptance and no debug re-entry is taken

`include "rvfi_defs.svh"

module trap_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Offered instruction
  input  logic                     instr_valid_i,
  input  logic                     instr_exc_i,
  input  logic [`RVFI_EXC_W-1:0]   instr_cause_i,
  input  logic                     stall_i,
  // Trap and debug requests
  input  logic                     irq_i,
  input  logic                     dbg_req_i,
  input  logic                     step_i,
  input  logic                     dbg_exit_i,
  // Retirement feedback from the tracker
  input  logic                     wb_retire_i,
  input  logic                     wb_trap_exc_i,
  input  logic [`RVFI_EXC_W-1:0]   wb_trap_cause_i,
  // Tags for the instruction entering IF
  output logic                     accept_o,
  output logic                     tag_intr_o,
  output rvfi_pkg::dbg_cause_e     tag_dbg_cause_o,
  output logic                     trap_exc_o,
  output logic [`RVFI_EXC_W-1:0]   trap_cause_o,
  output logic                     trap_dbg_o,
  // Acknowledgements and visible CSR state
  output logic                     irq_ack_o,
  output logic                     dbg_ack_o,
  output logic [`RVFI_EXC_W-1:0]   mcause_o,
  output logic                     debug_mode_o
);

  import rvfi_pkg::*;

  ctrl_state_e state_q, state_d;
  logic        in_run;

  // Step pending means the previous accepted instruction was stepped in RUN
  logic        step_pend_q, step_pend_d;
  // Handler pending means the previous accepted instruction raised an exception in RUN
  logic        hdl_pend_q, hdl_pend_d;

  logic [`RVFI_EXC_W-1:0] mcause_q;

  //////////////////////////////
  // Acceptance
  //////////////////////////////

  // A stall freezes the whole pipe, so nothing is taken while it is high
  assign accept_o = instr_valid_i && !stall_i;
  assign in_run   = (state_q == CTRL_RUN);

  // Exception fields travel with the instruction in any state
  assign trap_exc_o   = accept_o && instr_exc_i;
  assign trap_cause_o = instr_exc_i ? instr_cause_i : '0;

  // Every instruction taken in RUN with stepping enabled is a step trap
  assign trap_dbg_o = accept_o && in_run && step_i;

  //////////////////////////////
  // Tagging and next state
  //////////////////////////////

  always_comb begin
    state_d         = state_q;
    step_pend_d     = step_pend_q;
    hdl_pend_d      = hdl_pend_q;
    tag_intr_o      = 1'b0;
    tag_dbg_cause_o = DBG_NONE;
    irq_ack_o       = 1'b0;
    dbg_ack_o       = 1'b0;

    if (accept_o && in_run) begin
      if (step_pend_q) begin
        // The instruction after a step is the debug handler entry
        tag_dbg_cause_o = DBG_STEP;
        dbg_ack_o       = 1'b1;
        state_d         = CTRL_DEBUG;
      end else if (dbg_req_i) begin
        tag_dbg_cause_o = DBG_HALTREQ;
        dbg_ack_o       = 1'b1;
        state_d         = CTRL_DEBUG;
      end else begin
        // Interrupt entry and exception handler entry may land on one instruction
        if (irq_i) begin
          tag_intr_o = 1'b1;
          irq_ack_o  = 1'b1;
        end
        if (hdl_pend_q) begin
          tag_intr_o = 1'b1;
        end
      end
    end

    // Pending flags describe only the last accepted instruction
    if (accept_o) begin
      step_pend_d = in_run && step_i;
      hdl_pend_d  = in_run && instr_exc_i;
    end

    // Leaving debug mode drops anything that was pending on entry
    if (dbg_exit_i) begin
      state_d     = CTRL_RUN;
      step_pend_d = 1'b0;
      hdl_pend_d  = 1'b0;
    end
  end

  //////////////////////////////
  // State registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= CTRL_RUN;
      step_pend_q <= 1'b0;
      hdl_pend_q  <= 1'b0;
    end else begin
      state_q     <= state_d;
      step_pend_q <= step_pend_d;
      hdl_pend_q  <= hdl_pend_d;
    end
  end

  // mcause is frozen in DEBUG
  // Interrupt entry belongs to a younger instruction than the retiring one, so it wins
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mcause_q <= '0;
    end else if (in_run) begin
      if (irq_ack_o) begin
        mcause_q <= `RVFI_EXC_W'(`RVFI_IRQ_CAUSE);
      end else if (wb_retire_i && wb_trap_exc_i) begin
        mcause_q <= wb_trap_cause_i;
      end
    end
  end

  assign mcause_o     = mcause_q;
  assign debug_mode_o = (state_q == CTRL_DEBUG);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the trace unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_top -o Vtb_top
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/Vtb_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^All checks passed$" "$LOG"; then
  exit 0
else
  exit 1
fi

// ==== tb.f ====
+incdir+logic
logic/rvfi_pkg.sv
logic/trap_ctrl.sv
logic/rvfi_tracker.sv
logic/rvfi_top.sv
bench/tb_clk.sv
bench/rvfi_chk.sv
bench/tb_top.sv
